/* sim.f */
lpif_pkg.sv
flit_if.sv
ll_auto_sync.sv
lpif_flit_pack.sv
lpif_lane_concat.sv
lpif_link_top.sv
tb_lpif_link.sv

/* Makefile */
# Verilator build and run for the LPIF link adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_lpif_link
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_lpif_link.sv */
// Loopback of tx_phy to rx_phy with LANES = 3; outputs checked 2 units after each rising edge
module tb_lpif_link;

  localparam int LANES      = 3;
  // The tests need about 140 cycles, so this leaves wide margin
  localparam int MAX_CYCLES = 1000;

  logic                                          clk_wr;
  logic                                          reset;
  logic                                          tx_online;
  logic                                          rx_online;
  logic [7:0]                                    delay_x_value;
  logic [7:0]                                    delay_xz_value;
  logic [7:0]                                    delay_yz_value;
  lpif_pkg::lpif_state_e                         ustrm_state;
  logic [1:0]                                    ustrm_protid;
  logic [lpif_pkg::DATA_WIDTH-1:0]               ustrm_data;
  logic [lpif_pkg::BSTART_WIDTH-1:0]             ustrm_bstart;
  logic [lpif_pkg::BYTES-1:0]                    ustrm_bvalid;
  logic                                          ustrm_valid;
  lpif_pkg::lpif_state_e                         dstrm_state;
  logic [1:0]                                    dstrm_protid;
  logic [lpif_pkg::DATA_WIDTH-1:0]               dstrm_data;
  logic [lpif_pkg::BSTART_WIDTH-1:0]             dstrm_bstart;
  logic [lpif_pkg::BYTES-1:0]                    dstrm_bvalid;
  logic                                          dstrm_valid;
  logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    tx_phy;
  logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    rx_phy;
  logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    fault_mask;
  logic [15:0]                                   rx_error_count;
  logic                                          mrk_fault;

  int                              errors       = 0;
  int                              tests_run    = 0;
  int                              tests_passed = 0;
  int                              cycle_count  = 0;
  logic [15:0]                     exp_err_count;
  logic [lpif_pkg::DATA_WIDTH-1:0] last_data;
  lpif_pkg::lpif_state_e           last_state;
  lpif_pkg::lpif_flit_t            sent [0:99];
  logic                            rej  [0:99];

  lpif_link_top #(.LANES(LANES)) lpif_link_top_i (.*);

  // Loopback, with the lane 1 marker bit optionally cleared
  always_comb begin
    fault_mask = '0;
    fault_mask[1][lpif_pkg::LANE_WIDTH-2] = mrk_fault;
  end
  assign rx_phy = tx_phy & ~fault_mask;

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  always @(posedge clk_wr) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic flag_mismatch(input string what);
    errors++;
    $display("Mismatch at time %0t: %s", $time, what);
  endtask

  task automatic step_cycle();
    @(posedge clk_wr);
    #2;
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  function automatic lpif_pkg::lpif_state_e pick_state(input logic [2:0] idx);
    case (idx)
      3'd0: return lpif_pkg::RESET;
      3'd1: return lpif_pkg::ACTIVE;
      3'd2: return lpif_pkg::IDLE;
      3'd3: return lpif_pkg::L1;
      3'd4: return lpif_pkg::L2;
      3'd5: return lpif_pkg::LINKRESET;
      3'd6: return lpif_pkg::RETRAIN;
      default: return lpif_pkg::DISABLED;
    endcase
  endfunction

  // Roughly three of four beats are valid
  task automatic random_beat(output lpif_pkg::lpif_flit_t b);
    logic [31:0] r;
    r        = $urandom;
    b.state  = pick_state(r[2:0]);
    b.valid  = (r[5:4] != 2'b00);
    b.bstart = r[8:6];
    b.bvalid = r[16:9];
    b.protid = r[18:17];
    b.data   = {$urandom, $urandom};
  endtask

  task automatic apply_beat(input lpif_pkg::lpif_flit_t b);
    ustrm_state  = b.state;
    ustrm_protid = b.protid;
    ustrm_data   = b.data;
    ustrm_bstart = b.bstart;
    ustrm_bvalid = b.bvalid;
    ustrm_valid  = b.valid;
  endtask

  // Accepted valid beats pass whole, invalid ones only move state, rejected ones move nothing
  task automatic check_downstream(input lpif_pkg::lpif_flit_t beat, input logic accepted,
                                  input int idx);
    lpif_pkg::lpif_flit_t got;
    got = {dstrm_state, dstrm_protid, dstrm_data, dstrm_bstart, dstrm_bvalid, dstrm_valid};
    if (accepted && beat.valid) begin
      assert (got === beat)
        else flag_mismatch($sformatf("beat %0d got %h expected %h", idx, got, beat));
      last_data  = beat.data;
      last_state = beat.state;
    end else begin
      if (accepted) begin
        last_state = beat.state;
      end
      assert (!dstrm_valid) else flag_mismatch($sformatf("beat %0d dstrm_valid high", idx));
      assert (dstrm_data === last_data)
        else flag_mismatch($sformatf("beat %0d dstrm_data changed", idx));
      assert (dstrm_state === last_state)
        else flag_mismatch($sformatf("beat %0d dstrm_state %s expected %s", idx,
                                     dstrm_state.name(), last_state.name()));
    end
  endtask

  //////////////////////////////////////////////////
  // Protocol properties
  //////////////////////////////////////////////////

  // Lanes stay dark until five edges have seen tx_online high
  tx_offline_zero: assert property (@(posedge clk_wr) disable iff (reset)
    !$past(tx_online, 5) |-> (tx_phy == '0))
    else flag_mismatch("tx_phy not zero while tx is offline");

  // Seven sync edges, then the rx and downstream registers
  rx_offline_gate: assert property (@(posedge clk_wr) disable iff (reset)
    !$past(rx_online, 9) |-> !dstrm_valid)
    else flag_mismatch("dstrm_valid high while rx is offline");

  err_count_monotonic: assert property (@(posedge clk_wr) disable iff (reset)
    rx_error_count >= $past(rx_error_count))
    else flag_mismatch("rx_error_count decreased");

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int                   err_start;
    lpif_pkg::lpif_flit_t b;
    void'($urandom(83168));
    reset          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    mrk_fault      = 1'b0;
    delay_x_value  = 8'd4;
    delay_xz_value = 8'd5;
    delay_yz_value = 8'd3;
    exp_err_count  = '0;
    last_data      = '0;
    last_state     = lpif_pkg::RESET;
    apply_beat('0);
    step_cycle();
    step_cycle();
    reset = 1'b0;

    err_start = errors;
    assert (tx_phy == '0) else flag_mismatch("tx_phy not zero after reset");
    assert (!dstrm_valid) else flag_mismatch("dstrm_valid high after reset");
    assert (dstrm_state === lpif_pkg::RESET) else flag_mismatch("dstrm_state not RESET");
    assert (rx_error_count == 16'd0) else flag_mismatch("rx_error_count not zero");
    finish_test("reset values", err_start);

    // tx goes online on the fifth edge that sees tx_online high
    err_start = errors;
    tx_online = 1'b1;
    for (int i = 1; i <= 8; i++) begin
      step_cycle();
      for (int l = 0; l < LANES; l++) begin
        if (i < 5) begin
          assert (tx_phy[l] == '0) else flag_mismatch($sformatf("lane %0d early online", l));
        end else begin
          assert (tx_phy[l][lpif_pkg::LANE_WIDTH-1] && tx_phy[l][lpif_pkg::LANE_WIDTH-2])
            else flag_mismatch($sformatf("lane %0d marker or strobe missing", l));
        end
      end
    end
    finish_test("tx online delay", err_start);

    // rx online after 4 + 3 edges, then two register stages
    // Early words carry a bad marker that must not be counted while gated
    err_start = errors;
    rx_online = 1'b1;
    for (int i = 1; i <= 9; i++) begin
      step_cycle();
      if (i < 9) begin
        assert (!dstrm_valid) else flag_mismatch($sformatf("dstrm_valid early at %0d", i));
      end else begin
        assert (dstrm_valid) else flag_mismatch("dstrm_valid still low after rx online");
      end
      assert (rx_error_count == 16'd0) else flag_mismatch("rx_error_count moved while gated");
      random_beat(b);
      b.valid = 1'b1;
      apply_beat(b);
      mrk_fault = (i <= 4);
    end
    finish_test("rx gating", err_start);

    // A beat sampled on one edge is on dstrm two edges later
    err_start = errors;
    for (int i = 0; i < 103; i++) begin
      step_cycle();
      if (i >= 3) begin
        check_downstream(sent[i-3], 1'b1, i - 3);
      end
      random_beat(b);
      if (i == 0) begin
        b.valid = 1'b1;
      end else if (i >= 100) begin
        b.valid = 1'b0;
      end
      if (i < 100) begin
        sent[i] = b;
      end
      apply_beat(b);
    end
    assert (rx_error_count == exp_err_count) else flag_mismatch("rx_error_count moved");
    finish_test("loopback data", err_start);

    // Mask set on one tick spoils the word driven one tick before
    err_start = errors;
    for (int i = 0; i < 16; i++) begin
      rej[i] = 1'b0;
    end
    for (int i = 0; i < 19; i++) begin
      step_cycle();
      if (i >= 3) begin
        check_downstream(sent[i-3], !rej[i-3], i - 3);
      end
      random_beat(b);
      b.valid = (i < 16);
      if (i < 16) begin
        sent[i] = b;
      end
      apply_beat(b);
      mrk_fault = (i >= 4 && i < 10);
      if (mrk_fault) begin
        rej[i-1]      = 1'b1;
        exp_err_count = exp_err_count + 16'd1;
      end
    end
    assert (rx_error_count == exp_err_count)
      else flag_mismatch($sformatf("rx_error_count %0d expected %0d", rx_error_count,
                                   exp_err_count));
    finish_test("marker fault", err_start);

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
             tests_run - tests_passed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* lpif_link_top.sv */
// Single channel, full rate, no credits or ready; LANES must be at least 3
module lpif_link_top #(
  parameter int LANES = 3
) (
  input  logic                                          clk_wr,
  input  logic                                          reset,

  input  logic                                          tx_online,
  input  logic                                          rx_online,
  input  logic [7:0]                                    delay_x_value,
  input  logic [7:0]                                    delay_xz_value,
  input  logic [7:0]                                    delay_yz_value,

  // Upstream user beat
  input  lpif_pkg::lpif_state_e                         ustrm_state,
  input  logic [1:0]                                    ustrm_protid,
  input  logic [lpif_pkg::DATA_WIDTH-1:0]               ustrm_data,
  input  logic [lpif_pkg::BSTART_WIDTH-1:0]             ustrm_bstart,
  input  logic [lpif_pkg::BYTES-1:0]                    ustrm_bvalid,
  input  logic                                          ustrm_valid,

  // Downstream user beat
  output lpif_pkg::lpif_state_e                         dstrm_state,
  output logic [1:0]                                    dstrm_protid,
  output logic [lpif_pkg::DATA_WIDTH-1:0]               dstrm_data,
  output logic [lpif_pkg::BSTART_WIDTH-1:0]             dstrm_bstart,
  output logic [lpif_pkg::BYTES-1:0]                    dstrm_bvalid,
  output logic                                          dstrm_valid,

  // PHY side
  output logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    tx_phy,
  input  logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    rx_phy,

  output logic [15:0]                                   rx_error_count
);

  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_mrk_bit;
  logic tx_stb_bit;

  flit_if tx_flit ();
  flit_if rx_flit ();

  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk_bit      (tx_mrk_bit),
    .tx_stb_bit      (tx_stb_bit)
  );

  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr       (clk_wr),
    .reset        (reset),
    .ustrm_state  (ustrm_state),
    .ustrm_protid (ustrm_protid),
    .ustrm_data   (ustrm_data),
    .ustrm_bstart (ustrm_bstart),
    .ustrm_bvalid (ustrm_bvalid),
    .ustrm_valid  (ustrm_valid),
    .dstrm_state  (dstrm_state),
    .dstrm_protid (dstrm_protid),
    .dstrm_data   (dstrm_data),
    .dstrm_bstart (dstrm_bstart),
    .dstrm_bvalid (dstrm_bvalid),
    .dstrm_valid  (dstrm_valid),
    .tx_flit      (tx_flit.source),
    .rx_flit      (rx_flit.sink)
  );

  lpif_lane_concat #(
    .LANES (LANES)
  ) lpif_lane_concat_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk_bit      (tx_mrk_bit),
    .tx_stb_bit      (tx_stb_bit),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_error_count  (rx_error_count),
    .tx_flit         (tx_flit.sink),
    .rx_flit         (rx_flit.source)
  );

endmodule

/* lpif_lane_concat.sv */
// LANES must be 3 or more; spare payload bits go out as zero and are ignored on receive
module lpif_lane_concat #(
  parameter int LANES = 3
) (
  input  logic                                          clk_wr,
  input  logic                                          reset,

  input  logic                                          tx_online_delay,
  input  logic                                          rx_online_delay,
  input  logic                                          tx_mrk_bit,
  input  logic                                          tx_stb_bit,

  // PHY lane words
  output logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    tx_phy,
  input  logic [LANES-1:0][lpif_pkg::LANE_WIDTH-1:0]    rx_phy,

  output logic [15:0]                                   rx_error_count,

  flit_if.sink                                          tx_flit,
  flit_if.source                                        rx_flit
);

  localparam int PAYLOAD_BITS = LANES * lpif_pkg::LANE_PAYLOAD;
  localparam int PAD_BITS     = PAYLOAD_BITS - lpif_pkg::FLIT_WIDTH;

  //////////////////////////////////////////////////
  // Transmit
  //////////////////////////////////////////////////

  lpif_pkg::lpif_flit_t      tx_word;
  logic [PAYLOAD_BITS-1:0]   tx_pad;
  logic [PAYLOAD_BITS-1:0]   tx_pad_q;

  assign tx_word.state  = tx_flit.state;
  assign tx_word.protid = tx_flit.protid;
  assign tx_word.data   = tx_flit.data;
  assign tx_word.bstart = tx_flit.bstart;
  assign tx_word.bvalid = tx_flit.bvalid;
  assign tx_word.valid  = tx_flit.valid;

  assign tx_pad = {{PAD_BITS{1'b0}}, tx_word};

  always_ff @(posedge clk_wr) begin
    tx_pad_q <= tx_pad;
  end

  // Lane 0 carries the lsbs; offline lanes are held at zero
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (tx_online_delay) begin
        tx_phy[i] = {tx_stb_bit, tx_mrk_bit,
                     tx_pad_q[i*lpif_pkg::LANE_PAYLOAD +: lpif_pkg::LANE_PAYLOAD]};
      end else begin
        tx_phy[i] = '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Receive
  //////////////////////////////////////////////////

  logic [PAYLOAD_BITS-1:0]   rx_pad;
  logic                      lanes_ok;
  logic                      accept;
  lpif_pkg::lpif_flit_t      rx_word;

  lpif_pkg::lpif_state_e                 rx_state_q;
  logic                                  rx_valid_q;
  logic [1:0]                            rx_protid_q;
  logic [lpif_pkg::DATA_WIDTH-1:0]       rx_data_q;
  logic [lpif_pkg::BSTART_WIDTH-1:0]     rx_bstart_q;
  logic [lpif_pkg::BYTES-1:0]            rx_bvalid_q;

  // Strip marker and strobe, check them on every lane
  always_comb begin
    lanes_ok = 1'b1;
    for (int i = 0; i < LANES; i++) begin
      rx_pad[i*lpif_pkg::LANE_PAYLOAD +: lpif_pkg::LANE_PAYLOAD] =
        rx_phy[i][lpif_pkg::LANE_PAYLOAD-1:0];
      lanes_ok = lanes_ok & rx_phy[i][lpif_pkg::LANE_WIDTH-1] &
                 rx_phy[i][lpif_pkg::LANE_WIDTH-2];
    end
  end

  assign rx_word = lpif_pkg::lpif_flit_t'(rx_pad[lpif_pkg::FLIT_WIDTH-1:0]);
  assign accept  = rx_online_delay & lanes_ok;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_state_q     <= lpif_pkg::RESET;
      rx_valid_q     <= 1'b0;
      rx_error_count <= '0;
    end else begin
      rx_valid_q <= accept & rx_word.valid;
      if (accept) begin
        rx_state_q <= rx_word.state;
      end
      // Saturating count of bad words while online
      if (rx_online_delay && !lanes_ok && (rx_error_count != 16'hffff)) begin
        rx_error_count <= rx_error_count + 16'd1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      rx_protid_q <= rx_word.protid;
      rx_data_q   <= rx_word.data;
      rx_bstart_q <= rx_word.bstart;
      rx_bvalid_q <= rx_word.bvalid;
    end
  end

  assign rx_flit.state  = rx_state_q;
  assign rx_flit.valid  = rx_valid_q;
  assign rx_flit.protid = rx_protid_q;
  assign rx_flit.data   = rx_data_q;
  assign rx_flit.bstart = rx_bstart_q;
  assign rx_flit.bvalid = rx_bvalid_q;

endmodule

/* lpif_flit_pack.sv */
// Transmit side is combinational; downstream data fields hold their value on invalid beats
module lpif_flit_pack (
  input  logic                                clk_wr,
  input  logic                                reset,

  // Upstream user beat
  input  lpif_pkg::lpif_state_e               ustrm_state,
  input  logic [1:0]                          ustrm_protid,
  input  logic [lpif_pkg::DATA_WIDTH-1:0]     ustrm_data,
  input  logic [lpif_pkg::BSTART_WIDTH-1:0]   ustrm_bstart,
  input  logic [lpif_pkg::BYTES-1:0]          ustrm_bvalid,
  input  logic                                ustrm_valid,

  // Downstream user beat
  output lpif_pkg::lpif_state_e               dstrm_state,
  output logic [1:0]                          dstrm_protid,
  output logic [lpif_pkg::DATA_WIDTH-1:0]     dstrm_data,
  output logic [lpif_pkg::BSTART_WIDTH-1:0]   dstrm_bstart,
  output logic [lpif_pkg::BYTES-1:0]          dstrm_bvalid,
  output logic                                dstrm_valid,

  flit_if.source                              tx_flit,
  flit_if.sink                                rx_flit
);

  // Upstream beat goes straight onto the tx flit
  assign tx_flit.state  = ustrm_state;
  assign tx_flit.protid = ustrm_protid;
  assign tx_flit.data   = ustrm_data;
  assign tx_flit.bstart = ustrm_bstart;
  assign tx_flit.bvalid = ustrm_bvalid;
  assign tx_flit.valid  = ustrm_valid;

  // Rejected words arrive with state held, so state simply follows
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      dstrm_state <= lpif_pkg::RESET;
      dstrm_valid <= 1'b0;
    end else begin
      dstrm_state <= rx_flit.state;
      dstrm_valid <= rx_flit.valid;
    end
  end

  // Payload only on real beats
  always_ff @(posedge clk_wr) begin
    if (rx_flit.valid) begin
      dstrm_protid <= rx_flit.protid;
      dstrm_data   <= rx_flit.data;
      dstrm_bstart <= rx_flit.bstart;
      dstrm_bvalid <= rx_flit.bvalid;
    end
  end

endmodule

/* ll_auto_sync.sv */
// Delay-based online sequencing only; rx delay is x plus yz, a zero delay acts as one cycle
module ll_auto_sync (
  input  logic       clk_wr,
  input  logic       reset,

  input  logic       tx_online,
  input  logic       rx_online,

  // Word alignment time for the receive side
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  input  logic [7:0] delay_yz_value,

  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       tx_mrk_bit,
  output logic       tx_stb_bit
);

  //////////////////////////////////////////////////
  // Per-direction thresholds, index 0 is tx
  //////////////////////////////////////////////////

  logic [1:0]      online_in;
  logic [1:0][8:0] threshold;
  logic [1:0]      online_q;

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;

  assign threshold[0] = {1'b0, delay_xz_value};
  assign threshold[1] = {1'b0, delay_x_value} + {1'b0, delay_yz_value};

  //////////////////////////////////////////////////
  // Online delay FSMs
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    lpif_pkg::sync_state_e state_q;
    logic [8:0]            count_q;
    logic [8:0]            count_next;

    // Count includes the current edge
    assign count_next = count_q + 9'd1;

    always_ff @(posedge clk_wr) begin
      if (reset) begin
        state_q <= lpif_pkg::SYNC_OFFLINE;
        count_q <= '0;
      end else if (!online_in[ch]) begin
        // Any low cycle restarts the delay
        state_q <= lpif_pkg::SYNC_OFFLINE;
        count_q <= '0;
      end else begin
        case (state_q)
          lpif_pkg::SYNC_OFFLINE,
          lpif_pkg::SYNC_WAIT: begin
            count_q <= count_next;
            if (count_next >= threshold[ch]) begin
              state_q <= lpif_pkg::SYNC_ONLINE;
            end else begin
              state_q <= lpif_pkg::SYNC_WAIT;
            end
          end
          default: begin
            state_q <= lpif_pkg::SYNC_ONLINE;
          end
        endcase
      end
    end

    assign online_q[ch] = (state_q == lpif_pkg::SYNC_ONLINE);
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  // Full rate, so every word carries marker and strobe
  assign tx_mrk_bit = online_q[0];
  assign tx_stb_bit = online_q[0];

endmodule

/* flit_if.sv */
// One user beat as a plain level per clock; no handshake, valid marks a real beat
interface flit_if;

  lpif_pkg::lpif_state_e                 state;
  logic [1:0]                            protid;
  logic [lpif_pkg::DATA_WIDTH-1:0]       data;
  logic [lpif_pkg::BSTART_WIDTH-1:0]     bstart;
  logic [lpif_pkg::BYTES-1:0]            bvalid;
  logic                                  valid;

  // Producer of the beat
  modport source (
    output state, protid, data, bstart, bvalid, valid
  );

  // Consumer of the beat
  modport sink (
    input  state, protid, data, bstart, bvalid, valid
  );

endinterface

/* lpif_pkg.sv */
// Shared link constants and types; FLIT_WIDTH must equal the packed width of lpif_flit_t
package lpif_pkg;

  //////////////////////////////////////////////////
  // Lane and flit geometry
  //////////////////////////////////////////////////

  // PHY lane word, strobe in bit 39 and marker in bit 38
  parameter int LANE_WIDTH   = 40;
  parameter int LANE_PAYLOAD = 38;

  // User beat fields
  parameter int DATA_WIDTH   = 64;
  parameter int BYTES        = DATA_WIDTH / 8;
  parameter int BSTART_WIDTH = 3;

  // state + protid + data + bstart + bvalid + valid
  parameter int FLIT_WIDTH   = 4 + 2 + DATA_WIDTH + BSTART_WIDTH + BYTES + 1;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // LPIF link state encoding
  typedef enum logic [3:0] {
    RESET     = 4'h0,
    ACTIVE    = 4'h1,
    IDLE      = 4'h2,
    L1        = 4'h4,
    L2        = 4'h8,
    LINKRESET = 4'h9,
    RETRAIN   = 4'hb,
    DISABLED  = 4'hc
  } lpif_state_e;

  // One user beat, msb first in this order
  typedef struct packed {
    lpif_state_e             state;
    logic [1:0]              protid;
    logic [DATA_WIDTH-1:0]   data;
    logic [BSTART_WIDTH-1:0] bstart;
    logic [BYTES-1:0]        bvalid;
    logic                    valid;
  } lpif_flit_t;

  // Online delay sequencer
  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_WAIT,
    SYNC_ONLINE
  } sync_state_e;

endpackage
